/* verilog/cxl_defs.svh */
`ifndef CXL_DEFS_SVH
`define CXL_DEFS_SVH

// Payload and header field widths
`define CXL_DATA_W  64
`define CXL_ADDR_W  32
`define CXL_TAG_W   16

// Receive queue, one slot always left open
`define RXQ_DEPTH   8
`define RXQ_PTR_W   3

// Flit queue toward FDI
`define TXQ_DEPTH   16
`define TXQ_PTR_W   4

`define FLIT_BYTES  (`CXL_DATA_W / 8)

`endif

/* verilog/cxl_pkg.sv */
`include "cxl_defs.svh"

package cxl_pkg;

    typedef enum logic [1:0] {
        PROTO_IO    = 2'b00,
        PROTO_CACHE = 2'b01,
        PROTO_MEM   = 2'b10
    } proto_t;

    typedef enum logic [1:0] {
        MODE_IO    = 2'b00,
        MODE_CACHE = 2'b01,
        MODE_MEM   = 2'b10,
        MODE_ALL   = 2'b11
    } cxl_mode_t;

    typedef enum logic [5:0] {
        IO_MEM_READ      = 6'b000000,
        IO_MEM_WRITE     = 6'b000001,
        IO_CFG_READ      = 6'b000010,
        IO_CFG_WRITE     = 6'b000011,
        IO_COMPLETION    = 6'b000100,
        CACHE_SNOOP      = 6'b010000,
        CACHE_GO         = 6'b010001,
        CACHE_GO_ERR     = 6'b010010,
        CACHE_RSP_I      = 6'b010011,
        CACHE_RSP_S      = 6'b010100,
        CACHE_RSP_E      = 6'b010101,
        CACHE_RSP_M      = 6'b010110,
        CACHE_DATA       = 6'b010111,
        CACHE_DATA_E     = 6'b011000,
        CACHE_WRITEBACK  = 6'b011001,
        MEM_READ         = 6'b100000,
        MEM_WRITE        = 6'b100001,
        MEM_PARTIAL_WR   = 6'b100010,
        MEM_BI_READ      = 6'b100011,
        MEM_BI_WRITE     = 6'b100100,
        MEM_DATA         = 6'b100101,
        MEM_DATA_RESP    = 6'b100110,
        MEM_COMP         = 6'b100111
    } msg_type_t;

    typedef enum logic {
        FMT_68B  = 1'b0,
        FMT_256B = 1'b1
    } flit_fmt_t;

    typedef enum logic [1:0] {
        PH_IO    = 2'b00,
        PH_CACHE = 2'b01,
        PH_MEM   = 2'b10
    } arb_phase_t;

    typedef struct packed {
        logic [`CXL_DATA_W-1:0] data;
        logic [`CXL_ADDR_W-1:0] addr;
        logic [`CXL_TAG_W-1:0]  tag;
        logic [7:0]             length;
        msg_type_t              msg_type;
        logic [2:0]             prio;
    } cxl_txn_t;

    typedef struct packed {
        proto_t                proto;
        flit_fmt_t             fmt;
        logic [3:0]            prio;
        logic [`CXL_TAG_W-1:0] tag;
        msg_type_t             msg_type;
        logic [7:0]            length;
    } flit_hdr_t;

    typedef struct packed {
        flit_hdr_t              hdr;
        logic [`CXL_DATA_W-1:0] data;
    } cxl_flit_t;

endpackage

/* verilog/cxl_rx_queue.sv */
`timescale 1ns/1ps
`include "cxl_defs.svh"

module cxl_rx_queue #(
    parameter cxl_pkg::proto_t PROTO = cxl_pkg::PROTO_IO
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               engine_enable,
    input  cxl_pkg::cxl_mode_t cxl_mode,
    input  cxl_pkg::cxl_txn_t  rx_txn,
    input  logic               rx_valid,
    output logic               rx_ready,
    output cxl_pkg::cxl_txn_t  head,
    output logic               empty,
    input  logic               pop,
    output logic               full,
    output logic [31:0]        txn_count
);

    cxl_pkg::cxl_txn_t     slots [`RXQ_DEPTH];
    logic [`RXQ_PTR_W-1:0] wr_ptr, rd_ptr;
    logic [`RXQ_PTR_W-1:0] wr_ptr_nxt, rd_ptr_nxt;
    logic                  mode_ok, chan_en, accept, full_nxt;

    always_comb begin
        case (cxl_mode)
            cxl_pkg::MODE_IO:    mode_ok = (PROTO == cxl_pkg::PROTO_IO);
            cxl_pkg::MODE_CACHE: mode_ok = (PROTO == cxl_pkg::PROTO_CACHE);
            cxl_pkg::MODE_MEM:   mode_ok = (PROTO == cxl_pkg::PROTO_MEM);
            default:             mode_ok = 1'b1;
        endcase
    end

    assign chan_en = engine_enable && mode_ok;
    assign accept  = rx_valid && rx_ready;

    assign wr_ptr_nxt = wr_ptr + `RXQ_PTR_W'(accept);
    assign rd_ptr_nxt = rd_ptr + `RXQ_PTR_W'(pop);

    assign empty    = (wr_ptr == rd_ptr);
    assign full     = ((wr_ptr + 1'b1) == rd_ptr);
    assign full_nxt = ((wr_ptr_nxt + 1'b1) == rd_ptr_nxt); // Ready must see this edge's push
    assign head     = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (accept)
            slots[wr_ptr] <= rx_txn;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            rx_ready  <= 1'b0;
            txn_count <= 32'h0;
        end else begin
            wr_ptr   <= wr_ptr_nxt;
            rd_ptr   <= rd_ptr_nxt;
            rx_ready <= chan_en && !full_nxt;
            if (accept)
                txn_count <= txn_count + 32'd1;
        end
    end

    // Builder must only pop a queue that holds data
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

/* verilog/cxl_arbiter.sv */
`timescale 1ns/1ps

module cxl_arbiter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            engine_enable,
    input  logic [3:0]      io_weight,
    input  logic [3:0]      cache_weight,
    input  logic [3:0]      mem_weight,
    input  logic            io_empty,
    input  logic            cache_empty,
    input  logic            mem_empty,
    output cxl_pkg::proto_t grant
);

    cxl_pkg::arb_phase_t phase, phase_nxt;
    cxl_pkg::proto_t     grant_nxt;
    logic                io_ok, cache_ok, mem_ok;

    // Zero weight masks a channel out entirely
    assign io_ok    = !io_empty && (io_weight != 4'h0);
    assign cache_ok = !cache_empty && (cache_weight != 4'h0);
    assign mem_ok   = !mem_empty && (mem_weight != 4'h0);

    always_comb begin
        grant_nxt = grant;   // Hold when nobody qualifies
        phase_nxt = cxl_pkg::PH_IO;
        case (phase)
            cxl_pkg::PH_IO: begin
                phase_nxt = cxl_pkg::PH_CACHE;
                if (io_ok)         grant_nxt = cxl_pkg::PROTO_IO;
                else if (cache_ok) grant_nxt = cxl_pkg::PROTO_CACHE;
                else if (mem_ok)   grant_nxt = cxl_pkg::PROTO_MEM;
            end
            cxl_pkg::PH_CACHE: begin
                phase_nxt = cxl_pkg::PH_MEM;
                if (cache_ok)      grant_nxt = cxl_pkg::PROTO_CACHE;
                else if (mem_ok)   grant_nxt = cxl_pkg::PROTO_MEM;
                else if (io_ok)    grant_nxt = cxl_pkg::PROTO_IO;
            end
            default: begin
                phase_nxt = cxl_pkg::PH_IO;
                if (mem_ok)        grant_nxt = cxl_pkg::PROTO_MEM;
                else if (io_ok)    grant_nxt = cxl_pkg::PROTO_IO;
                else if (cache_ok) grant_nxt = cxl_pkg::PROTO_CACHE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= cxl_pkg::PH_IO;
            grant <= cxl_pkg::PROTO_IO;
        end else if (engine_enable) begin
            phase <= phase_nxt;
            grant <= grant_nxt;
        end
    end

endmodule

/* verilog/cxl_flit_builder.sv */
`timescale 1ns/1ps

module cxl_flit_builder (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              engine_enable,
    input  logic              coherency_enable,
    input  cxl_pkg::proto_t   grant,
    input  cxl_pkg::cxl_txn_t io_head,
    input  cxl_pkg::cxl_txn_t cache_head,
    input  cxl_pkg::cxl_txn_t mem_head,
    input  logic              io_empty,
    input  logic              cache_empty,
    input  logic              mem_empty,
    output logic              io_pop,
    output logic              cache_pop,
    output logic              mem_pop,
    output cxl_pkg::cxl_flit_t flit,
    output logic              push,
    input  logic              tx_full,
    output logic [15:0]       coherency_state
);

    cxl_pkg::cxl_txn_t sel_txn;
    logic              sel_empty;

    always_comb begin
        case (grant)
            cxl_pkg::PROTO_CACHE: begin
                sel_txn   = cache_head;
                sel_empty = cache_empty;
            end
            cxl_pkg::PROTO_MEM: begin
                sel_txn   = mem_head;
                sel_empty = mem_empty;
            end
            default: begin
                sel_txn   = io_head;
                sel_empty = io_empty;
            end
        endcase
    end

    // At most one transaction popped and pushed per edge
    assign push      = engine_enable && !tx_full && !sel_empty;
    assign io_pop    = push && (grant == cxl_pkg::PROTO_IO);
    assign cache_pop = push && (grant == cxl_pkg::PROTO_CACHE);
    assign mem_pop   = push && (grant == cxl_pkg::PROTO_MEM);

    always_comb begin
        flit.hdr.proto    = grant;
        flit.hdr.fmt      = (grant == cxl_pkg::PROTO_IO) ? cxl_pkg::FMT_68B : cxl_pkg::FMT_256B;
        flit.hdr.prio     = {1'b0, sel_txn.prio};
        flit.hdr.tag      = sel_txn.tag;
        flit.hdr.msg_type = sel_txn.msg_type;
        flit.hdr.length   = sel_txn.length;
        flit.data         = sel_txn.data;
    end

    // One nibble per cache response state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coherency_state <= 16'h0;
        end else if (cache_pop && coherency_enable) begin
            case (sel_txn.msg_type)
                cxl_pkg::CACHE_RSP_I: coherency_state[3:0]   <= 4'b0001;
                cxl_pkg::CACHE_RSP_S: coherency_state[7:4]   <= 4'b0010;
                cxl_pkg::CACHE_RSP_E: coherency_state[11:8]  <= 4'b0100;
                cxl_pkg::CACHE_RSP_M: coherency_state[15:12] <= 4'b1000;
                default: ;
            endcase
        end
    end

    // Every pushed flit pops exactly one receive queue
    a_one_pop: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> $onehot({io_pop, cache_pop, mem_pop}));

endmodule

/* verilog/cxl_fdi_tx.sv */
`timescale 1ns/1ps
`include "cxl_defs.svh"

module cxl_fdi_tx (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               engine_enable,
    input  cxl_pkg::cxl_flit_t flit,
    input  logic               push,
    output logic               tx_full,
    output cxl_pkg::cxl_flit_t fdi_tx_flit,
    output logic               fdi_tx_valid,
    input  logic               fdi_tx_ready,
    output logic [31:0]        bytes_sent
);

    cxl_pkg::cxl_flit_t    slots [`TXQ_DEPTH];
    logic [`TXQ_PTR_W-1:0] wr_ptr, rd_ptr;
    logic                  empty, drain;

    assign empty   = (wr_ptr == rd_ptr);
    assign tx_full = ((wr_ptr + 1'b1) == rd_ptr);
    assign drain   = engine_enable && !empty && fdi_tx_ready;

    always_ff @(posedge clk) begin
        if (push)
            slots[wr_ptr] <= flit;
        if (drain)
            fdi_tx_flit <= slots[rd_ptr];  // Output payload, held between strobes
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fdi_tx_valid <= 1'b0;
            bytes_sent   <= 32'h0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            fdi_tx_valid <= drain;  // Strobe, one cycle per flit
            if (drain) begin
                rd_ptr     <= rd_ptr + 1'b1;
                bytes_sent <= bytes_sent + 32'(`FLIT_BYTES);
            end
        end
    end

    // Builder stalls on tx_full
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !tx_full);

endmodule

/* verilog/cxl_protocol_engine.sv */
`timescale 1ns/1ps

module cxl_protocol_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               engine_enable,
    input  cxl_pkg::cxl_mode_t cxl_mode,
    input  logic               coherency_enable,
    input  cxl_pkg::cxl_txn_t  io_rx_txn,
    input  logic               io_rx_valid,
    output logic               io_rx_ready,
    input  cxl_pkg::cxl_txn_t  cache_rx_txn,
    input  logic               cache_rx_valid,
    output logic               cache_rx_ready,
    input  cxl_pkg::cxl_txn_t  mem_rx_txn,
    input  logic               mem_rx_valid,
    output logic               mem_rx_ready,
    input  logic [3:0]         io_weight,
    input  logic [3:0]         cache_weight,
    input  logic [3:0]         mem_weight,
    output cxl_pkg::cxl_flit_t fdi_tx_flit,
    output logic               fdi_tx_valid,
    input  logic               fdi_tx_ready,
    output cxl_pkg::proto_t    active_protocol,
    output logic [15:0]        cache_coherency_state,
    output logic [31:0]        io_transactions,
    output logic [31:0]        cache_transactions,
    output logic [31:0]        mem_transactions,
    output logic [31:0]        total_bytes_transferred,
    output logic               protocol_error
);

    cxl_pkg::cxl_txn_t  io_head, cache_head, mem_head;
    cxl_pkg::cxl_flit_t flit;
    logic io_empty, cache_empty, mem_empty;
    logic io_pop, cache_pop, mem_pop;
    logic io_full, cache_full, mem_full;
    logic push, tx_full;

    cxl_rx_queue #(.PROTO(cxl_pkg::PROTO_IO)) i_io_rxq (
        .clk, .rst_n, .engine_enable, .cxl_mode,
        .rx_txn(io_rx_txn), .rx_valid(io_rx_valid), .rx_ready(io_rx_ready),
        .head(io_head), .empty(io_empty), .pop(io_pop), .full(io_full),
        .txn_count(io_transactions)
    );

    cxl_rx_queue #(.PROTO(cxl_pkg::PROTO_CACHE)) i_cache_rxq (
        .clk, .rst_n, .engine_enable, .cxl_mode,
        .rx_txn(cache_rx_txn), .rx_valid(cache_rx_valid), .rx_ready(cache_rx_ready),
        .head(cache_head), .empty(cache_empty), .pop(cache_pop), .full(cache_full),
        .txn_count(cache_transactions)
    );

    cxl_rx_queue #(.PROTO(cxl_pkg::PROTO_MEM)) i_mem_rxq (
        .clk, .rst_n, .engine_enable, .cxl_mode,
        .rx_txn(mem_rx_txn), .rx_valid(mem_rx_valid), .rx_ready(mem_rx_ready),
        .head(mem_head), .empty(mem_empty), .pop(mem_pop), .full(mem_full),
        .txn_count(mem_transactions)
    );

    cxl_arbiter i_arbiter (
        .clk, .rst_n, .engine_enable,
        .io_weight, .cache_weight, .mem_weight,
        .io_empty, .cache_empty, .mem_empty,
        .grant(active_protocol)
    );

    cxl_flit_builder i_flit_builder (
        .clk, .rst_n, .engine_enable, .coherency_enable,
        .grant(active_protocol),
        .io_head, .cache_head, .mem_head,
        .io_empty, .cache_empty, .mem_empty,
        .io_pop, .cache_pop, .mem_pop,
        .flit, .push, .tx_full,
        .coherency_state(cache_coherency_state)
    );

    cxl_fdi_tx i_fdi_tx (
        .clk, .rst_n, .engine_enable,
        .flit, .push, .tx_full,
        .fdi_tx_flit, .fdi_tx_valid, .fdi_tx_ready,
        .bytes_sent(total_bytes_transferred)
    );

    assign protocol_error = |{io_full, cache_full, mem_full};  // Level, no state

endmodule

/* tests/tb_cxl_checks.svh */
`ifndef TB_CXL_CHECKS_SVH
`define TB_CXL_CHECKS_SVH

int value_errors = 0;
int other_errors = 0;   // Protocol misbehavior, no single value to compare

task automatic report_error(input string msg);
    other_errors++;
    $display("ERROR at %0t: %s", $time, msg);
endtask

task automatic check_flit(input cxl_pkg::cxl_flit_t got, input cxl_pkg::cxl_flit_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("FAIL %0t: flit tag %h of protocol %0d is %h, expected %h",
                 $time, exp.hdr.tag, exp.hdr.proto, got, exp);
    end
endtask

task automatic check_count(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        value_errors++;
        $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_coh(input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
        value_errors++;
        $display("FAIL %0t: coherency state is %h, expected %h", $time, got, exp);
    end
endtask

`endif

/* tests/tb_cxl_protocol_engine.sv */
`timescale 1ns/1ps

module tb_cxl_protocol_engine;

    `include "tb_cxl_checks.svh"

    typedef struct packed {
        cxl_pkg::proto_t    chan;
        cxl_pkg::msg_type_t msg;
        cxl_pkg::cxl_mode_t mode;
        logic [11:0]        wts;      // io, cache, mem
        logic               coh;
        logic               fdi_rdy;
        logic               chk_full; // Queue must be full after this accept
        logic               sync;     // Drain, then compare counters and state
    } entry_t;

    logic                clk;
    logic                rst_n;
    logic                engine_enable;
    cxl_pkg::cxl_mode_t  cxl_mode;
    logic                coherency_enable;
    cxl_pkg::cxl_txn_t   rx_txn [3];
    logic [2:0]          rx_valid;
    logic                io_rx_ready, cache_rx_ready, mem_rx_ready;
    logic [3:0]          io_weight, cache_weight, mem_weight;
    cxl_pkg::cxl_flit_t  fdi_tx_flit;
    logic                fdi_tx_valid;
    logic                fdi_tx_ready;
    cxl_pkg::proto_t     active_protocol;
    logic [15:0]         cache_coherency_state;
    logic [31:0]         io_transactions, cache_transactions, mem_transactions;
    logic [31:0]         total_bytes_transferred;
    logic                protocol_error;
    logic [2:0]          rdy_vec;

    entry_t              stim_q [$];
    cxl_pkg::cxl_flit_t  exp_q [4][$];   // Per protocol, in acceptance order
    int unsigned         acc_cnt [3] = '{0, 0, 0};
    logic [15:0]         exp_coh = '0;
    logic [31:0]         lfsr = 32'hafab56d7;
    logic                rdy_at_edge = 1'b0;
    int                  mon_ch;

    assign rdy_vec = {mem_rx_ready, cache_rx_ready, io_rx_ready};

    cxl_protocol_engine i_cxl_protocol_engine (
        .clk, .rst_n, .engine_enable, .cxl_mode, .coherency_enable,
        .io_rx_txn(rx_txn[0]), .io_rx_valid(rx_valid[0]), .io_rx_ready,
        .cache_rx_txn(rx_txn[1]), .cache_rx_valid(rx_valid[1]), .cache_rx_ready,
        .mem_rx_txn(rx_txn[2]), .mem_rx_valid(rx_valid[2]), .mem_rx_ready,
        .io_weight, .cache_weight, .mem_weight,
        .fdi_tx_flit, .fdi_tx_valid, .fdi_tx_ready,
        .active_protocol, .cache_coherency_state,
        .io_transactions, .cache_transactions, .mem_transactions,
        .total_bytes_transferred, .protocol_error
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // Channel index follows proto_t encoding
    function automatic logic mode_allows(input cxl_pkg::cxl_mode_t m, input int c);
        case (m)
            cxl_pkg::MODE_IO:    return c == 0;
            cxl_pkg::MODE_CACHE: return c == 1;
            cxl_pkg::MODE_MEM:   return c == 2;
            default:             return 1'b1;
        endcase
    endfunction

    task automatic add_stim(input cxl_pkg::proto_t ch, input cxl_pkg::msg_type_t m,
                            input cxl_pkg::cxl_mode_t md, input logic [15:0] code);
        stim_q.push_back(entry_t'({ch, m, md, code}));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic run_entry(input entry_t e, input int idx);
        cxl_pkg::cxl_txn_t  t;
        cxl_pkg::cxl_flit_t ef;
        logic               rdy;
        if (e.mode != cxl_mode) begin
            cxl_mode = e.mode;
            repeat (2) next_cycle();   // Readies follow the mode one edge later
        end
        {io_weight, cache_weight, mem_weight} = e.wts;
        coherency_enable = e.coh;
        fdi_tx_ready     = e.fdi_rdy;
        t.data     = rand_bits(64);
        t.addr     = 32'(rand_bits(32));
        t.tag      = 16'(idx);
        t.length   = 8'(rand_bits(8));
        t.msg_type = e.msg;
        t.prio     = 3'(rand_bits(3));
        rx_txn[e.chan] = t;
        for (int c = 0; c < 3; c++)
            rx_valid[c] = (c == int'(e.chan)) || !mode_allows(e.mode, c); // Probe gated ones
        do begin
            rdy = rdy_vec[e.chan];
            for (int c = 0; c < 3; c++)
                if (!mode_allows(e.mode, c) && rdy_vec[c])
                    report_error($sformatf("channel %0d ready while its mode is off", c));
            next_cycle();
        end while (!rdy);
        rx_valid = '0;

        ef.hdr.proto    = e.chan;
        ef.hdr.fmt      = (e.chan == cxl_pkg::PROTO_IO) ? cxl_pkg::FMT_68B : cxl_pkg::FMT_256B;
        ef.hdr.prio     = {1'b0, t.prio};
        ef.hdr.tag      = t.tag;
        ef.hdr.msg_type = t.msg_type;
        ef.hdr.length   = t.length;
        ef.data         = t.data;
        exp_q[e.chan].push_back(ef);
        acc_cnt[e.chan]++;
        if (e.coh && e.chan == cxl_pkg::PROTO_CACHE) begin
            case (e.msg)
                cxl_pkg::CACHE_RSP_I: exp_coh[3:0]   = 4'b0001;
                cxl_pkg::CACHE_RSP_S: exp_coh[7:4]   = 4'b0010;
                cxl_pkg::CACHE_RSP_E: exp_coh[11:8]  = 4'b0100;
                cxl_pkg::CACHE_RSP_M: exp_coh[15:12] = 4'b1000;
                default: ;
            endcase
        end

        if (e.chk_full) begin
            check_count(32'(rdy_vec[e.chan]), 32'd0, "ready of a full queue");
            check_count(32'(protocol_error), 32'd1, "protocol_error with a full queue");
        end
        if (e.sync) begin
            while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() > 0)
                next_cycle();
            check_coh(cache_coherency_state, exp_coh);
            check_count(io_transactions, acc_cnt[0], "io transaction count");
            check_count(cache_transactions, acc_cnt[1], "cache transaction count");
            check_count(mem_transactions, acc_cnt[2], "mem transaction count");
            check_count(total_bytes_transferred, 8 * (acc_cnt[0] + acc_cnt[1] + acc_cnt[2]),
                        "byte count");
        end
    endtask

    // Ready as the DUT saw it on the edge that raised valid
    always @(posedge clk) rdy_at_edge <= fdi_tx_ready;

    always @(negedge clk) begin
        if (rst_n && fdi_tx_valid) begin
            mon_ch = fdi_tx_flit.hdr.proto;
            if (!rdy_at_edge)
                report_error("flit sent while FDI ready was low");
            if (exp_q[mon_ch].size() == 0)
                report_error($sformatf("flit of protocol %0d that was never sent", mon_ch));
            else
                check_flit(fdi_tx_flit, exp_q[mon_ch].pop_front());
        end
    end

    initial begin
        rst_n            = 1'b0;
        engine_enable    = 1'b0;
        cxl_mode         = cxl_pkg::MODE_ALL;
        coherency_enable = 1'b0;
        rx_txn           = '{default: '0};
        rx_valid         = '0;
        {io_weight, cache_weight, mem_weight} = 12'h111;
        fdi_tx_ready     = 1'b0;

        // Code digits: io, cache, mem weight, then flags coh/fdi_rdy/chk_full/sync
        add_stim(cxl_pkg::PROTO_IO, cxl_pkg::IO_MEM_WRITE, cxl_pkg::MODE_ALL, 16'h111_4);
        add_stim(cxl_pkg::PROTO_CACHE, cxl_pkg::CACHE_SNOOP, cxl_pkg::MODE_ALL, 16'h111_4);
        add_stim(cxl_pkg::PROTO_MEM, cxl_pkg::MEM_READ, cxl_pkg::MODE_ALL, 16'h111_4);
        add_stim(cxl_pkg::PROTO_IO, cxl_pkg::IO_CFG_READ, cxl_pkg::MODE_ALL, 16'h111_4);
        add_stim(cxl_pkg::PROTO_MEM, cxl_pkg::MEM_WRITE, cxl_pkg::MODE_ALL, 16'h111_4);
        add_stim(cxl_pkg::PROTO_CACHE, cxl_pkg::CACHE_DATA, cxl_pkg::MODE_ALL, 16'h111_5);
        add_stim(cxl_pkg::PROTO_CACHE, cxl_pkg::CACHE_GO, cxl_pkg::MODE_CACHE, 16'h111_4);
        add_stim(cxl_pkg::PROTO_CACHE, cxl_pkg::CACHE_WRITEBACK, cxl_pkg::MODE_CACHE, 16'h111_5);
        // Mem weight zero, queue fills and then drains once the weight returns
        repeat (6) add_stim(cxl_pkg::PROTO_MEM, cxl_pkg::MEM_PARTIAL_WR, cxl_pkg::MODE_ALL, 16'h110_4);
        add_stim(cxl_pkg::PROTO_MEM, cxl_pkg::MEM_BI_WRITE, cxl_pkg::MODE_ALL, 16'h110_6);
        add_stim(cxl_pkg::PROTO_MEM, cxl_pkg::MEM_DATA, cxl_pkg::MODE_ALL, 16'h111_5);
        add_stim(cxl_pkg::PROTO_CACHE, cxl_pkg::CACHE_RSP_M, cxl_pkg::MODE_ALL, 16'h111_5);
        add_stim(cxl_pkg::PROTO_CACHE, cxl_pkg::CACHE_RSP_I, cxl_pkg::MODE_ALL, 16'h111_D);
        add_stim(cxl_pkg::PROTO_CACHE, cxl_pkg::CACHE_RSP_S, cxl_pkg::MODE_ALL, 16'h111_D);
        add_stim(cxl_pkg::PROTO_CACHE, cxl_pkg::CACHE_RSP_E, cxl_pkg::MODE_ALL, 16'h111_5);
        add_stim(cxl_pkg::PROTO_CACHE, cxl_pkg::CACHE_RSP_E, cxl_pkg::MODE_ALL, 16'h111_D);
        add_stim(cxl_pkg::PROTO_CACHE, cxl_pkg::CACHE_RSP_M, cxl_pkg::MODE_ALL, 16'h111_D);
        // FDI held off, enough traffic to fill the flit queue
        repeat (12) add_stim(cxl_pkg::PROTO_IO, cxl_pkg::IO_MEM_READ, cxl_pkg::MODE_ALL, 16'h111_0);
        add_stim(cxl_pkg::PROTO_IO, cxl_pkg::IO_COMPLETION, cxl_pkg::MODE_ALL, 16'h111_0);
        add_stim(cxl_pkg::PROTO_MEM, cxl_pkg::MEM_COMP, cxl_pkg::MODE_ALL, 16'h111_0);
        add_stim(cxl_pkg::PROTO_CACHE, cxl_pkg::CACHE_GO_ERR, cxl_pkg::MODE_ALL, 16'h111_0);
        add_stim(cxl_pkg::PROTO_IO, cxl_pkg::IO_CFG_WRITE, cxl_pkg::MODE_ALL, 16'h111_0);
        add_stim(cxl_pkg::PROTO_MEM, cxl_pkg::MEM_BI_READ, cxl_pkg::MODE_ALL, 16'h111_0);
        add_stim(cxl_pkg::PROTO_CACHE, cxl_pkg::CACHE_DATA_E, cxl_pkg::MODE_ALL, 16'h111_5);

        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
        check_count({28'h0, rdy_vec, fdi_tx_valid}, 32'd0, "readies and fdi_tx_valid after reset");
        check_count(io_transactions | cache_transactions | mem_transactions, 32'd0,
                    "transaction counters after reset");
        check_count(total_bytes_transferred, 32'd0, "byte count after reset");
        check_count(32'(protocol_error), 32'd0, "protocol_error after reset");
        check_count(32'(active_protocol), 32'(cxl_pkg::PROTO_IO), "active_protocol after reset");
        check_coh(cache_coherency_state, 16'h0);
        engine_enable = 1'b1;

        foreach (stim_q[i])
            run_entry(stim_q[i], i);

        $display("Run done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        #1;
        repeat (stim_q.size() * 200) @(posedge clk);
        $display("Timeout: stimulus did not complete within %0d cycles", stim_q.size() * 200);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* all.f */
+incdir+verilog
+incdir+tests
verilog/cxl_pkg.sv
verilog/cxl_rx_queue.sv
verilog/cxl_arbiter.sv
verilog/cxl_flit_builder.sv
verilog/cxl_fdi_tx.sv
verilog/cxl_protocol_engine.sv
tests/tb_cxl_protocol_engine.sv
